// ==== Makefile ====
# Verilator build and run for the mic echo testbench

VERILATOR ?= verilator
TOP       ?= mic_echo_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || (echo "simulation reported failure"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/mic_echo_checker.sv ====
`timescale 1ns/1ps

module mic_echo_checker import audio_pkg::*; (
  input  logic           audio_clk,
  input  logic           rst_in,
  input  logic           bclk,
  input  logic           lrcl,
  input  sample_strobe_t monitor,
  input  logic           speaker_left,
  input  logic           speaker_right,
  input  logic           frame_start,
  input  int             test_id,
  input  int             frame_idx,
  input  logic           exp_pulse,
  input  int             exp_level,
  input  logic           run_done,
  output int             err_count,
  output logic           report_done
);

  localparam int TEST_PDM   = 6;
  localparam int PDM_WINDOW = 4096;

  logic rst_q = 1'b1;
  logic start_q = 1'b0;
  logic exp_q = 1'b0;
  logic done_q = 1'b0;
  int   id_q, fidx_q, lvl_q;
  int   errors = 0;
  int   clock_errs = 0;
  int   test_errs = 0;
  int   tests_run = 0;
  int   tests_failed = 0;
  int   cur_test = 0;
  int   cur_frame, cur_lvl;
  logic cur_exp = 1'b0;
  logic pulse_seen = 1'b0;
  logic prev_bclk = 1'b0;
  logic prev_lrcl = 1'b0;
  logic bclk_seen = 1'b0;
  logic lrcl_seen = 1'b0;
  int   bclk_gap = 0;
  int   lrcl_gap = 0;
  int   pdm_state = 0;
  int   pdm_pulses, pdm_cycles, ones_left, ones_right, pdm_level;
  logic done_flag = 1'b0;

  assign err_count   = errors;
  assign report_done = done_flag;

  function automatic string test_name(int id);
    case (id)
      1: return "raw_capture";
      2: return "conditioning";
      3: return "delay";
      4: return "echo";
      5: return "mute";
      6: return "pdm";
      default: return "unknown";
    endcase
  endfunction

  task automatic note_error();
    test_errs++;
    errors++;
  endtask

  task automatic close_frame();
    if (cur_test != 0 && cur_exp && !pulse_seen) begin
      $display("no monitor pulse in frame %0d of test %s", cur_frame, test_name(cur_test));
      note_error();
    end
  endtask

  task automatic close_test();
    if (cur_test == TEST_PDM && pdm_state != 2) begin
      $display("pdm measurement window did not complete in test %s", test_name(cur_test));
      note_error();
    end
    tests_run++;
    if (test_errs == 0) begin
      $display("test %s: ok", test_name(cur_test));
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name(cur_test), test_errs);
    end
  endtask

  // tb inputs change on the falling edge and are taken here
  always @(posedge audio_clk) begin
    rst_q   = rst_in;
    start_q = frame_start;
    id_q    = test_id;
    fidx_q  = frame_idx;
    exp_q   = exp_pulse;
    lvl_q   = exp_level;
    done_q  = run_done;
  end

  // dut outputs are stable at the falling edge
  always @(negedge audio_clk) begin
    if (rst_q) begin
      if (bclk || lrcl || monitor.valid || speaker_left || speaker_right) begin
        $display("an output is high during reset at %0t", $time);
        clock_errs++;
        errors++;
      end
    end else if (!done_flag) begin
      bclk_gap++;
      lrcl_gap++;
      if (bclk && !prev_bclk) begin
        if (bclk_seen && bclk_gap != 2 * BCLK_HALF) begin
          $display("bclk period is %0d cycles at %0t", bclk_gap, $time);
          clock_errs++;
          errors++;
        end
        bclk_seen = 1'b1;
        bclk_gap  = 0;
      end
      if (!lrcl && prev_lrcl) begin
        if (lrcl_seen && lrcl_gap != 2 * BCLK_HALF * FRAME_BCLKS) begin
          $display("lrcl period is %0d cycles at %0t", lrcl_gap, $time);
          clock_errs++;
          errors++;
        end
        lrcl_seen = 1'b1;
        lrcl_gap  = 0;
      end
      prev_bclk = bclk;
      prev_lrcl = lrcl;

      if (start_q) begin
        close_frame();
        if (id_q != cur_test) begin
          if (cur_test != 0) begin
            close_test();
          end
          cur_test   = id_q;
          test_errs  = 0;
          pdm_state  = 0;
          pdm_pulses = 0;
        end
        cur_frame  = fidx_q;
        cur_exp    = exp_q;
        cur_lvl    = lvl_q;
        pulse_seen = 1'b0;
      end

      if (pdm_state == 1) begin
        ones_left  += speaker_left;
        ones_right += speaker_right;
        pdm_cycles++;
        if (pdm_cycles == PDM_WINDOW) begin
          int expected;
          expected = (PDM_WINDOW * (pdm_level + 32768)) / 65536;
          if (ones_left > expected + 1 || ones_left < expected - 1) begin
            $display("Mismatch test %s speaker_left ones expected %0d actual %0d",
                     test_name(cur_test), expected, ones_left);
            note_error();
          end
          if (ones_right != 0) begin
            $display("Mismatch test %s speaker_right ones expected 0 actual %0d",
                     test_name(cur_test), ones_right);
            note_error();
          end
          pdm_state = 2;
        end
      end

      if (monitor.valid) begin
        if (!cur_exp || pulse_seen) begin
          $display("unexpected monitor pulse in frame %0d of test %s",
                   cur_frame, test_name(cur_test));
          note_error();
        end else begin
          pulse_seen = 1'b1;
          if (monitor.data !== cur_lvl) begin
            $display("Mismatch test %s frame %0d expected %0d actual %0d",
                     test_name(cur_test), cur_frame, cur_lvl, monitor.data);
            note_error();
          end
          // level has been held since the first pulse of the test
          if (cur_test == TEST_PDM && pdm_state == 0) begin
            pdm_pulses++;
            if (pdm_pulses == 2) begin
              pdm_state  = 1;
              pdm_cycles = 0;
              ones_left  = 0;
              ones_right = 0;
              pdm_level  = cur_lvl;
            end
          end
        end
      end

      if (done_q) begin
        close_frame();
        if (cur_test != 0) begin
          close_test();
        end
        $display("tests %0d, failed %0d, clock errors %0d, total errors %0d",
                 tests_run, tests_failed, clock_errs, errors);
        done_flag = 1'b1;
      end
    end
  end

endmodule

// ==== bench/mic_echo_stimulus.txt ====
# test_id select delay_sw enable mic_word(hex) expect_pulse expected_level
# select: 0 mute, 1 raw, 2 conditioned, 3 delayed, 4 echo
1 1 0 3 1234 1 4660
1 1 0 3 fedc 1 -292
1 1 0 3 8001 1 -32767
1 1 0 3 7abc 1 31420
2 2 0 3 0100 1 1152
2 2 0 3 2222 0 0
2 2 0 3 7d00 1 32767
2 2 0 3 1111 0 0
3 3 1 3 0a00 1 5556
3 3 1 3 3333 0 0
3 3 1 3 f000 1 -31871
3 3 1 3 0000 0 0
3 3 2 3 0400 1 0
3 3 2 3 5555 0 0
4 4 1 3 0800 1 17855
4 4 1 3 6666 0 0
4 4 1 3 e000 1 -1920
4 4 1 3 7777 0 0
5 0 0 3 1abc 0 0
5 0 0 3 9876 0 0
6 1 0 1 4000 1 16384
6 1 0 1 4000 1 16384
6 1 0 1 4000 1 16384
6 1 0 1 4000 1 16384

// ==== bench/mic_echo_tb.sv ====
`timescale 1ns/1ps

module mic_echo_tb import audio_pkg::*; ();

  localparam string STIM_FILE      = "bench/mic_echo_stimulus.txt";
  localparam int    MAX_FRAMES     = 64;
  localparam int    FRAME_CYCLES   = 2 * BCLK_HALF * FRAME_BCLKS;
  localparam int    TIMEOUT_MARGIN = 4096;

  logic                     audio_clk = 1'b0;
  logic                     rst_in;
  logic                     mic_data;
  logic [DELAY_SW_BITS-1:0] delay_sw;
  source_sel_t              source_sel;
  logic [1:0]               speaker_enable;
  logic                     bclk;
  logic                     lrcl;
  sample_strobe_t           monitor;
  logic                     speaker_left;
  logic                     speaker_right;

  int   t_id [MAX_FRAMES];
  int   t_sel [MAX_FRAMES];
  int   t_dly [MAX_FRAMES];
  int   t_en [MAX_FRAMES];
  int   t_word [MAX_FRAMES];
  int   t_exp [MAX_FRAMES];
  int   t_lvl [MAX_FRAMES];
  int   n_frames = 0;
  int   cycles = 0;
  int   seed = 32'hdcaf37d3;
  logic [15:0] cur_word;

  logic frame_start;
  int   cur_test;
  int   frame_idx;
  logic exp_pulse;
  int   exp_level;
  logic run_done;
  int   err_count;
  logic report_done;

  always #4 audio_clk = ~audio_clk;

  mic_echo_top dut0 (
    .audio_clk      (audio_clk),
    .rst_in         (rst_in),
    .mic_data       (mic_data),
    .delay_sw       (delay_sw),
    .source_sel     (source_sel),
    .speaker_enable (speaker_enable),
    .bclk           (bclk),
    .lrcl           (lrcl),
    .monitor        (monitor),
    .speaker_left   (speaker_left),
    .speaker_right  (speaker_right)
  );

  mic_echo_checker chk0 (
    .audio_clk     (audio_clk),
    .rst_in        (rst_in),
    .bclk          (bclk),
    .lrcl          (lrcl),
    .monitor       (monitor),
    .speaker_left  (speaker_left),
    .speaker_right (speaker_right),
    .frame_start   (frame_start),
    .test_id       (cur_test),
    .frame_idx     (frame_idx),
    .exp_pulse     (exp_pulse),
    .exp_level     (exp_level),
    .run_done      (run_done),
    .err_count     (err_count),
    .report_done   (report_done)
  );

  // controls and expectation for one microphone frame
  task automatic apply_frame(int f);
    source_sel     = source_sel_t'(t_sel[f]);
    delay_sw       = DELAY_SW_BITS'(t_dly[f]);
    speaker_enable = 2'(t_en[f]);
    cur_word       = 16'(t_word[f]);
    cur_test       = t_id[f];
    frame_idx      = f;
    exp_pulse      = (t_exp[f] != 0);
    exp_level      = t_lvl[f];
    frame_start    = 1'b1;
  endtask

  initial begin
    int    fd;
    int    n;
    int    frame;
    int    bit_pos;
    int    filler;
    logic  prev_bclk;
    string line;
    int    a, b, c, d, e, g, h;
    rst_in         = 1'b1;
    mic_data       = 1'b0;
    delay_sw       = '0;
    source_sel     = src_mute;
    speaker_enable = 2'b00;
    cur_word       = '0;
    frame_start    = 1'b0;
    cur_test       = 0;
    frame_idx      = 0;
    exp_pulse      = 1'b0;
    exp_level      = 0;
    run_done       = 1'b0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("cannot open stimulus file %s", STIM_FILE);
      $display("STATUS: FAIL");
      $finish;
    end else begin
      while (!$feof(fd) && n_frames < MAX_FRAMES) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line[0] != "#") begin
          n = $sscanf(line, "%d %d %d %d %h %d %d", a, b, c, d, e, g, h);
          if (n == 7) begin
            t_id[n_frames]   = a;
            t_sel[n_frames]  = b;
            t_dly[n_frames]  = c;
            t_en[n_frames]   = d;
            t_word[n_frames] = e;
            t_exp[n_frames]  = g;
            t_lvl[n_frames]  = h;
            n_frames++;
          end
        end
      end
      $fclose(fd);
      repeat (16) @(negedge audio_clk);
      rst_in    = 1'b0;
      frame     = 0;
      bit_pos   = 0;
      prev_bclk = 1'b0;
      if (n_frames > 0) begin
        apply_frame(0);
      end
      // mic shifts a new bit out on every falling bclk
      while (frame < n_frames) begin
        @(negedge audio_clk);
        frame_start = 1'b0;
        if (prev_bclk && !bclk) begin
          bit_pos = (bit_pos + 1) % FRAME_BCLKS;
          if (bit_pos == 0) begin
            frame++;
            if (frame < n_frames) begin
              apply_frame(frame);
            end
          end
          if (bit_pos >= 1 && bit_pos <= SAMPLE_BITS) begin
            mic_data = cur_word[SAMPLE_BITS - bit_pos];
          end else begin
            filler   = $random(seed);
            mic_data = filler[0];
          end
        end
        prev_bclk = bclk;
      end
      run_done = 1'b1;
      wait (report_done);
      if (n_frames == 0) begin
        $display("stimulus file holds no frames");
      end
      if (err_count == 0 && n_frames > 0) begin
        $display("STATUS: PASS");
      end else begin
        $display("STATUS: FAIL");
      end
      $finish;
    end
  end

  always @(posedge audio_clk) begin
    cycles++;
    if (n_frames > 0 && cycles > n_frames * FRAME_CYCLES + 16 + TIMEOUT_MARGIN) begin
      $display("timeout, run did not finish within %0d cycles", cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

endmodule

// ==== build.f ====
source/audio_pkg.sv
source/i2s_receiver.sv
source/sample_conditioner.sv
source/audio_delay_line.sv
source/speaker_output.sv
source/mic_echo_top.sv
bench/mic_echo_checker.sv
bench/mic_echo_tb.sv

// ==== source/audio_delay_line.sv ====
`timescale 1ns/1ps

module audio_delay_line import audio_pkg::*; (
  input  logic                     audio_clk,
  input  logic                     rst_in,
  input  logic [DELAY_SW_BITS-1:0] delay_sw,
  input  sample_strobe_t           sample_in,
  output sample_strobe_t           sample_out
);

  sample_t                 mem [DELAY_DEPTH];
  logic [DELAY_ADDR_W-1:0] wr_ptr;
  logic [DELAY_ADDR_W-1:0] rd_addr;
  logic [DELAY_ADDR_W-1:0] delay_len;
  logic [DELAY_ADDR_W:0]   fill;
  logic                    short_history;
  logic                    valid_q;
  sample_t                 data_q;

  // switches count in steps of four samples
  assign delay_len = {delay_sw, 2'b00};
  assign rd_addr   = wr_ptr - delay_len;

  // not enough samples written yet for this delay
  assign short_history = (fill < {1'b0, delay_len});

  always_ff @(posedge audio_clk) begin
    if (rst_in) begin
      wr_ptr  <= '0;
      fill    <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= sample_in.valid;
      if (sample_in.valid) begin
        wr_ptr <= wr_ptr + 1'b1;
        if (fill != (DELAY_ADDR_W + 1)'(DELAY_DEPTH)) begin
          fill <= fill + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge audio_clk) begin
    if (sample_in.valid) begin
      mem[wr_ptr] <= sample_in.data;
    end
  end

  // zero delay returns the incoming sample itself
  always_ff @(posedge audio_clk) begin
    if (sample_in.valid) begin
      if (delay_len == '0) begin
        data_q <= sample_in.data;
      end else if (short_history) begin
        data_q <= '0;
      end else begin
        data_q <= mem[rd_addr];
      end
    end
  end

  assign sample_out = '{valid: valid_q, data: data_q};

endmodule

// ==== source/audio_pkg.sv ====
package audio_pkg;

  // one signed audio word
  typedef logic signed [15:0] sample_t;

  // stage to stage bus, valid is a one-cycle strobe
  typedef struct packed {
    logic    valid;
    sample_t data;
  } sample_strobe_t;

  // playback source choices
  typedef enum logic [2:0] {
    src_mute,
    src_raw,
    src_conditioned,
    src_delayed,
    src_echo
  } source_sel_t;

  // i2s clocking, audio_clk cycles per bclk half and bclk per frame
  localparam int BCLK_HALF   = 16;
  localparam int FRAME_BCLKS = 64;
  localparam int BCLK_HALF_W = $clog2(BCLK_HALF);
  localparam int FRAME_BIT_W = $clog2(FRAME_BCLKS);

  // bits kept from the left slot
  localparam int SAMPLE_BITS = 16;

  // measured mic offset
  localparam sample_t DC_OFFSET = -16'sd896;

  // delay buffer, switch value is in units of 4 samples
  localparam int DELAY_DEPTH   = 256;
  localparam int DELAY_ADDR_W  = $clog2(DELAY_DEPTH);
  localparam int DELAY_SW_BITS = 6;

endpackage

// ==== source/i2s_receiver.sv ====
`timescale 1ns/1ps

module i2s_receiver import audio_pkg::*; (
  input  logic           audio_clk,
  input  logic           rst_in,
  input  logic           mic_data,
  output logic           bclk,
  output logic           lrcl,
  output sample_strobe_t sample
);

  logic [BCLK_HALF_W-1:0] half_cnt;
  logic [FRAME_BIT_W-1:0] bit_cnt;
  logic                   half_end;
  logic                   bclk_rise;
  logic                   bclk_fall;
  logic                   in_slot;
  logic [SAMPLE_BITS-1:0] shift_reg;
  logic                   word_done;
  logic                   valid_q;
  sample_t                data_q;

  assign half_end  = (half_cnt == BCLK_HALF_W'(BCLK_HALF - 1));
  assign bclk_rise = half_end && !bclk;
  assign bclk_fall = half_end && bclk;

  // mic word sits in bclk periods 1..16 of the left slot
  assign in_slot = (bit_cnt >= 1) && (bit_cnt <= SAMPLE_BITS);

  // right slot is the upper half of the frame
  assign lrcl = (bit_cnt >= FRAME_BIT_W'(FRAME_BCLKS / 2));

  always_ff @(posedge audio_clk) begin
    if (rst_in) begin
      half_cnt  <= '0;
      bclk      <= 1'b0;
      bit_cnt   <= '0;
      word_done <= 1'b0;
      valid_q   <= 1'b0;
    end else begin
      half_cnt <= half_end ? '0 : half_cnt + 1'b1;
      if (half_end) begin
        bclk <= !bclk;
      end
      // frame position moves on the falling bclk edge
      if (bclk_fall) begin
        bit_cnt <= (bit_cnt == FRAME_BIT_W'(FRAME_BCLKS - 1)) ? '0 : bit_cnt + 1'b1;
      end
      word_done <= bclk_rise && (bit_cnt == FRAME_BIT_W'(SAMPLE_BITS));
      valid_q   <= word_done;
    end
  end

  // msb first, sampled as bclk goes high
  always_ff @(posedge audio_clk) begin
    if (bclk_rise && in_slot) begin
      shift_reg <= {shift_reg[SAMPLE_BITS-2:0], mic_data};
    end
    if (word_done) begin
      data_q <= sample_t'(shift_reg);
    end
  end

  assign sample = '{valid: valid_q, data: data_q};

endmodule

// ==== source/mic_echo_top.sv ====
`timescale 1ns/1ps

module mic_echo_top import audio_pkg::*; (
  input  logic                     audio_clk,
  input  logic                     rst_in,
  input  logic                     mic_data,
  input  logic [DELAY_SW_BITS-1:0] delay_sw,
  input  source_sel_t              source_sel,
  input  logic [1:0]               speaker_enable,
  output logic                     bclk,
  output logic                     lrcl,
  output sample_strobe_t           monitor,
  output logic                     speaker_left,
  output logic                     speaker_right
);

  sample_strobe_t raw;
  sample_strobe_t cond;
  sample_strobe_t delayed;

  i2s_receiver mic0 (
    .audio_clk (audio_clk),
    .rst_in    (rst_in),
    .mic_data  (mic_data),
    .bclk      (bclk),
    .lrcl      (lrcl),
    .sample    (raw)
  );

  // 48 kHz down to 24 kHz, offset removed
  sample_conditioner cond0 (
    .audio_clk  (audio_clk),
    .rst_in     (rst_in),
    .sample_in  (raw),
    .sample_out (cond)
  );

  audio_delay_line delay0 (
    .audio_clk  (audio_clk),
    .rst_in     (rst_in),
    .delay_sw   (delay_sw),
    .sample_in  (cond),
    .sample_out (delayed)
  );

  speaker_output spk0 (
    .audio_clk      (audio_clk),
    .rst_in         (rst_in),
    .source_sel     (source_sel),
    .raw            (raw),
    .cond           (cond),
    .delayed        (delayed),
    .speaker_enable (speaker_enable),
    .monitor        (monitor),
    .speaker_left   (speaker_left),
    .speaker_right  (speaker_right)
  );

endmodule

// ==== source/sample_conditioner.sv ====
`timescale 1ns/1ps

module sample_conditioner import audio_pkg::*; (
  input  logic           audio_clk,
  input  logic           rst_in,
  input  sample_strobe_t sample_in,
  output sample_strobe_t sample_out
);

  logic               drop_next;
  logic               keep;
  logic signed [16:0] diff;
  sample_t            clamped;
  logic               valid_q;
  sample_t            data_q;

  // 2:1 decimation, first pulse after reset is kept
  assign keep = sample_in.valid && !drop_next;

  assign diff = sample_in.data - DC_OFFSET;

  // clamp to the 16-bit signed range
  always_comb begin
    case (diff[16:15])
      2'b01:   clamped = 16'sh7fff;
      2'b10:   clamped = 16'sh8000;
      default: clamped = diff[15:0];
    endcase
  end

  always_ff @(posedge audio_clk) begin
    if (rst_in) begin
      drop_next <= 1'b0;
      valid_q   <= 1'b0;
    end else begin
      if (sample_in.valid) begin
        drop_next <= !drop_next;
      end
      valid_q <= keep;
    end
  end

  always_ff @(posedge audio_clk) begin
    if (keep) begin
      data_q <= clamped;
    end
  end

  assign sample_out = '{valid: valid_q, data: data_q};

endmodule

// ==== source/speaker_output.sv ====
`timescale 1ns/1ps

module speaker_output import audio_pkg::*; (
  input  logic           audio_clk,
  input  logic           rst_in,
  input  source_sel_t    source_sel,
  input  sample_strobe_t raw,
  input  sample_strobe_t cond,
  input  sample_strobe_t delayed,
  input  logic [1:0]     speaker_enable,
  output sample_strobe_t monitor,
  output logic           speaker_left,
  output logic           speaker_right
);

  logic               sel_valid;
  sample_t            sel_level;
  logic signed [16:0] echo_sum;
  logic               mon_valid;
  sample_t            mon_level;
  logic [15:0]        pdm_acc;
  logic [16:0]        pdm_sum;

  // cond is still held when delayed pulses
  assign echo_sum = cond.data + delayed.data;

  always_comb begin
    sel_valid = 1'b0;
    sel_level = '0;
    case (source_sel)
      src_raw: begin
        sel_valid = raw.valid;
        sel_level = raw.data;
      end
      src_conditioned: begin
        sel_valid = cond.valid;
        sel_level = cond.data;
      end
      src_delayed: begin
        sel_valid = delayed.valid;
        sel_level = delayed.data;
      end
      src_echo: begin
        sel_valid = delayed.valid;
        sel_level = echo_sum[16:1];
      end
      default: begin
        sel_valid = 1'b0;
        sel_level = '0;
      end
    endcase
  end

  // offset binary level, carry out is the pdm bit
  assign pdm_sum = {1'b0, pdm_acc} + {1'b0, ~mon_level[15], mon_level[14:0]};

  always_ff @(posedge audio_clk) begin
    if (rst_in) begin
      mon_valid     <= 1'b0;
      mon_level     <= '0;
      pdm_acc       <= '0;
      speaker_left  <= 1'b0;
      speaker_right <= 1'b0;
    end else begin
      mon_valid <= sel_valid;
      if (source_sel == src_mute) begin
        mon_level <= '0;
      end else if (sel_valid) begin
        mon_level <= sel_level;
      end
      pdm_acc       <= pdm_sum[15:0];
      speaker_left  <= speaker_enable[0] && pdm_sum[16];
      speaker_right <= speaker_enable[1] && pdm_sum[16];
    end
  end

  assign monitor = '{valid: mon_valid, data: mon_level};

endmodule
